// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       := gssl_rx_tb
FILELIST  := gssl_rx.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -E '\.s?v$$' $(FILELIST)) verif/gssl_rx_tb_tasks.svh

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// File: design/gssl_frame_pkg.sv
`default_nettype none

package gssl_frame_pkg;

	// data bytes per word, low byte first
	localparam int WORD_BYTES = 4;
	localparam int WORD_W     = 32;

	// RAM address, word count and L share one width
	localparam int ADDR_W = 8;
	localparam int CHS_W  = 8;

	// sequencer states
	typedef enum logic [2:0]
	{
		FS_IDLE,
		FS_BYTE,
		FS_CHS,
		FS_SYNC,
		FS_EOF
	} frame_state_t;

	// byte position inside a word
	typedef logic [$clog2(WORD_BYTES)-1:0] byte_slot_t;

endpackage

`default_nettype wire

// File: design/gssl_frame_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module gssl_frame_sequencer
(
	input  wire                                   GSSL_RXCLK,
	input  wire                                   rst_in,
	input  wire gssl_symbol_pkg::sym_class_t      sym_class,
	input  wire [gssl_symbol_pkg::BYTE_W-1:0]     sym_data,
	input  wire                                   sym_valid,
	output logic                                  byte_en,
	output gssl_frame_pkg::byte_slot_t            byte_slot,
	output logic                                  chs_en,
	output logic                                  word_commit,
	output logic [gssl_frame_pkg::ADDR_W-1:0]     word_idx,
	output logic [gssl_frame_pkg::ADDR_W-1:0]     head_len,
	output logic [gssl_frame_pkg::ADDR_W-1:0]     head_base,
	output logic                                  frame_start,
	output logic [gssl_symbol_pkg::BYTE_W-1:0]    word_data,
	output logic [2*gssl_frame_pkg::ADDR_W-1:0]   rx_frame_head_data,
	output logic                                  rx_ttc_trigger,
	output logic                                  rx_frame_busy,
	output logic                                  rx_frame_done,
	output logic                                  rx_frame_seq_err
);

	import gssl_symbol_pkg::*;
	import gssl_frame_pkg::*;

	frame_state_t state;
	byte_slot_t   slot;
	logic         expected;

	assign rx_frame_head_data = {head_base, head_len};

	// symbols each state accepts, TTC aside
	// a SYNC where a data byte belongs just stalls the frame
	always_comb
	begin
		case (state)
			FS_IDLE: expected = (sym_class == SYM_DATA) || (sym_class == SYM_SOF) ||
				(sym_class == SYM_SYNC);
			FS_BYTE, FS_CHS: expected = (sym_class == SYM_DATA) || (sym_class == SYM_SYNC);
			FS_SYNC: expected = (sym_class == SYM_SYNC);
			FS_EOF: expected = (sym_class == SYM_EOF) || (sym_class == SYM_SYNC);
			default: expected = 1'b0;
		endcase
	end

	always_ff @(posedge GSSL_RXCLK or posedge rst_in)
	begin
		if (rst_in)
		begin
			state            <= FS_IDLE;
			slot             <= '0;
			word_idx         <= '0;
			head_len         <= '0;
			head_base        <= '0;
			byte_en          <= 1'b0;
			byte_slot        <= '0;
			chs_en           <= 1'b0;
			word_commit      <= 1'b0;
			frame_start      <= 1'b0;
			rx_ttc_trigger   <= 1'b0;
			rx_frame_busy    <= 1'b0;
			rx_frame_done    <= 1'b0;
			rx_frame_seq_err <= 1'b0;
		end
		else
		begin
			// strobes last one cycle
			byte_en          <= 1'b0;
			chs_en           <= 1'b0;
			word_commit      <= 1'b0;
			frame_start      <= 1'b0;
			rx_ttc_trigger   <= 1'b0;
			rx_frame_done    <= 1'b0;
			rx_frame_seq_err <= 1'b0;

			if (sym_valid)
			begin
				if (sym_class == SYM_TTC)
					rx_ttc_trigger <= 1'b1;
				else if (!expected)
				begin
					// abort, frame progress is discarded
					state            <= FS_IDLE;
					rx_frame_busy    <= 1'b0;
					rx_frame_seq_err <= 1'b1;
				end
				else
				begin
					case (state)
						FS_IDLE:
						begin
							if (sym_class == SYM_SOF)
							begin
								state         <= FS_BYTE;
								slot          <= '0;
								word_idx      <= '0;
								frame_start   <= 1'b1;
								rx_frame_busy <= 1'b1;
							end
						end
						FS_BYTE:
						begin
							if (sym_class == SYM_DATA)
							begin
								byte_en   <= 1'b1;
								byte_slot <= slot;
								slot      <= slot + 1'b1;
								if (slot == byte_slot_t'(WORD_BYTES - 1))
									state <= FS_CHS;
								// head word carries L and base
								if (word_idx == '0 && slot == byte_slot_t'(0))
									head_len <= sym_data;
								if (word_idx == '0 && slot == byte_slot_t'(1))
									head_base <= sym_data;
							end
						end
						FS_CHS:
						begin
							if (sym_class == SYM_DATA)
							begin
								chs_en <= 1'b1;
								state  <= FS_SYNC;
							end
						end
						FS_SYNC:
						begin
							word_commit <= 1'b1;
							if (word_idx == head_len)
								state <= FS_EOF;
							else
							begin
								state    <= FS_BYTE;
								word_idx <= word_idx + 1'b1;
							end
						end
						FS_EOF:
						begin
							if (sym_class == SYM_EOF)
							begin
								state         <= FS_IDLE;
								rx_frame_busy <= 1'b0;
								rx_frame_done <= 1'b1;
							end
						end
						default: state <= FS_IDLE;
					endcase
				end
			end
		end
	end

	always_ff @(posedge GSSL_RXCLK)
	begin
		word_data <= sym_data;
	end

	a_idle_not_busy: assert property (@(posedge GSSL_RXCLK) disable iff (rst_in)
		(state == FS_IDLE) |-> !rx_frame_busy);

	// commit strobe is issued on the way out of FS_SYNC
	a_commit_from_sync: assert property (@(posedge GSSL_RXCLK) disable iff (rst_in)
		word_commit |-> ($past(state) == FS_SYNC));

endmodule

`default_nettype wire

// File: design/gssl_rx_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module gssl_rx_receiver
(
	input  wire                                  GSSL_RXCLK,
	input  wire                                  rst_in,
	input  wire                                  chs_ctrl,
	input  wire                                  decode_k,
	input  wire [gssl_symbol_pkg::BYTE_W-1:0]    decode_data,
	output logic [gssl_frame_pkg::WORD_W-1:0]    rx_dpram_data,
	output logic [gssl_frame_pkg::ADDR_W-1:0]    rx_dpram_waddress,
	output logic                                 rx_dpram_wr,
	output logic [2*gssl_frame_pkg::ADDR_W-1:0]  rx_frame_head_data,
	output logic                                 rx_ttc_trigger,
	output logic                                 rx_frame_busy,
	output logic                                 rx_frame_done,
	output logic                                 rx_frame_chs_err,
	output logic                                 rx_frame_seq_err
);

	import gssl_symbol_pkg::*;
	import gssl_frame_pkg::*;

	// classifier to sequencer
	sym_class_t        sym_class;
	logic [BYTE_W-1:0] sym_data;
	logic              sym_valid;

	// sequencer to word builder
	logic              byte_en;
	byte_slot_t        byte_slot;
	logic              chs_en;
	logic              word_commit;
	logic [ADDR_W-1:0] word_idx;
	logic [ADDR_W-1:0] head_len;
	logic [ADDR_W-1:0] head_base;
	logic              frame_start;
	logic [BYTE_W-1:0] word_data;

	gssl_symbol_classifier u_classifier
	(
		.GSSL_RXCLK  (GSSL_RXCLK),
		.rst_in      (rst_in),
		.decode_k    (decode_k),
		.decode_data (decode_data),
		.sym_class   (sym_class),
		.sym_data    (sym_data),
		.sym_valid   (sym_valid)
	);

	gssl_frame_sequencer u_sequencer
	(
		.GSSL_RXCLK         (GSSL_RXCLK),
		.rst_in             (rst_in),
		.sym_class          (sym_class),
		.sym_data           (sym_data),
		.sym_valid          (sym_valid),
		.byte_en            (byte_en),
		.byte_slot          (byte_slot),
		.chs_en             (chs_en),
		.word_commit        (word_commit),
		.word_idx           (word_idx),
		.head_len           (head_len),
		.head_base          (head_base),
		.frame_start        (frame_start),
		.word_data          (word_data),
		.rx_frame_head_data (rx_frame_head_data),
		.rx_ttc_trigger     (rx_ttc_trigger),
		.rx_frame_busy      (rx_frame_busy),
		.rx_frame_done      (rx_frame_done),
		.rx_frame_seq_err   (rx_frame_seq_err)
	);

	gssl_word_builder u_word_builder
	(
		.GSSL_RXCLK        (GSSL_RXCLK),
		.rst_in            (rst_in),
		.chs_ctrl          (chs_ctrl),
		.byte_en           (byte_en),
		.byte_slot         (byte_slot),
		.chs_en            (chs_en),
		.word_commit       (word_commit),
		.word_idx          (word_idx),
		.head_len          (head_len),
		.head_base         (head_base),
		.frame_start       (frame_start),
		.word_data         (word_data),
		.rx_dpram_data     (rx_dpram_data),
		.rx_dpram_waddress (rx_dpram_waddress),
		.rx_dpram_wr       (rx_dpram_wr),
		.rx_frame_chs_err  (rx_frame_chs_err)
	);

endmodule

`default_nettype wire

// File: design/gssl_symbol_classifier.sv
`timescale 1ns/1ns
`default_nettype none

module gssl_symbol_classifier
(
	input  wire                                 GSSL_RXCLK,
	input  wire                                 rst_in,
	input  wire                                 decode_k,
	input  wire [gssl_symbol_pkg::BYTE_W-1:0]   decode_data,
	output gssl_symbol_pkg::sym_class_t         sym_class,
	output logic [gssl_symbol_pkg::BYTE_W-1:0]  sym_data,
	output logic                                sym_valid
);

	import gssl_symbol_pkg::*;

	logic              k_q;
	logic [BYTE_W-1:0] data_q;
	logic              valid_q;

	// input sample stage
	always_ff @(posedge GSSL_RXCLK or posedge rst_in)
	begin
		if (rst_in)
		begin
			k_q     <= 1'b1;
			valid_q <= 1'b0;
		end
		else
		begin
			k_q     <= decode_k;
			valid_q <= 1'b1;
		end
	end

	always_ff @(posedge GSSL_RXCLK)
	begin
		data_q   <= decode_data;
		sym_data <= data_q;
	end

	// class stage, one cycle behind the sample
	always_ff @(posedge GSSL_RXCLK or posedge rst_in)
	begin
		if (rst_in)
		begin
			sym_class <= SYM_SYNC;
			sym_valid <= 1'b0;
		end
		else
		begin
			sym_valid <= valid_q;
			if (!k_q)
				sym_class <= SYM_DATA;
			else
			begin
				case (data_q)
					K_SOF:   sym_class <= SYM_SOF;
					K_EOF:   sym_class <= SYM_EOF;
					K_TTC:   sym_class <= SYM_TTC;
					K_SYNC:  sym_class <= SYM_SYNC;
					default: sym_class <= SYM_BAD;
				endcase
			end
		end
	end

	// the sequencer must only ever see a defined class
	a_class_legal: assert property (@(posedge GSSL_RXCLK) disable iff (rst_in)
		sym_valid |-> sym_class inside {SYM_DATA, SYM_SOF, SYM_EOF, SYM_TTC, SYM_SYNC, SYM_BAD});

endmodule

`default_nettype wire

// File: design/gssl_symbol_pkg.sv
`default_nettype none

package gssl_symbol_pkg;

	// width of one decoded symbol
	localparam int BYTE_W = 8;

	// K28.x values as delivered by the 8b/10b decoder
	localparam logic [BYTE_W-1:0] K_SOF  = 8'h1c;
	localparam logic [BYTE_W-1:0] K_EOF  = 8'h3c;
	localparam logic [BYTE_W-1:0] K_TTC  = 8'h5c;
	localparam logic [BYTE_W-1:0] K_SYNC = 8'hbc;

	// class of a registered symbol
	// any K-code not listed above, ATC included, lands in SYM_BAD
	typedef enum logic [2:0]
	{
		SYM_DATA,
		SYM_SOF,
		SYM_EOF,
		SYM_TTC,
		SYM_SYNC,
		SYM_BAD
	} sym_class_t;

endpackage

`default_nettype wire

// File: design/gssl_word_builder.sv
`timescale 1ns/1ns
`default_nettype none

module gssl_word_builder
(
	input  wire                                  GSSL_RXCLK,
	input  wire                                  rst_in,
	input  wire                                  chs_ctrl,
	input  wire                                  byte_en,
	input  wire gssl_frame_pkg::byte_slot_t      byte_slot,
	input  wire                                  chs_en,
	input  wire                                  word_commit,
	input  wire [gssl_frame_pkg::ADDR_W-1:0]     word_idx,
	input  wire [gssl_frame_pkg::ADDR_W-1:0]     head_len,
	input  wire [gssl_frame_pkg::ADDR_W-1:0]     head_base,
	input  wire                                  frame_start,
	input  wire [gssl_symbol_pkg::BYTE_W-1:0]    word_data,
	output logic [gssl_frame_pkg::WORD_W-1:0]    rx_dpram_data,
	output logic [gssl_frame_pkg::ADDR_W-1:0]    rx_dpram_waddress,
	output logic                                 rx_dpram_wr,
	output logic                                 rx_frame_chs_err
);

	import gssl_symbol_pkg::*;
	import gssl_frame_pkg::*;

	logic [WORD_W-1:0] word_q;
	logic [CHS_W-1:0]  sum_q;
	logic [CHS_W-1:0]  chs_sum;
	logic [CHS_W-1:0]  chs_exp;
	logic [ADDR_W-1:0] addr_q;
	logic              wr_pend;

	// S = four bytes + L - k
	// on the head word L is byte 0, so that byte counts twice
	assign chs_sum = sum_q + head_len - word_idx;

	// chs_ctrl high selects positive polarity
	assign chs_exp = chs_ctrl ? chs_sum + 1'b1 : ~chs_sum;

	always_ff @(posedge GSSL_RXCLK)
	begin
		if (byte_en)
		begin
			word_q[byte_slot*BYTE_W +: BYTE_W] <= word_data;
			if (byte_slot == '0)
				sum_q <= word_data;
			else
				sum_q <= sum_q + word_data;
		end

		// target address, k is still the current word here
		if (chs_en)
			addr_q <= head_base + word_idx - 1'b1;

		if (word_commit)
		begin
			rx_dpram_data     <= word_q;
			rx_dpram_waddress <= addr_q;
		end
	end

	always_ff @(posedge GSSL_RXCLK or posedge rst_in)
	begin
		if (rst_in)
		begin
			wr_pend          <= 1'b0;
			rx_dpram_wr      <= 1'b0;
			rx_frame_chs_err <= 1'b0;
		end
		else
		begin
			rx_dpram_wr      <= word_commit && wr_pend;
			rx_frame_chs_err <= chs_en && (word_data != chs_exp);

			// only data words (k >= 1) are written
			if (frame_start || word_commit)
				wr_pend <= 1'b0;
			else if (chs_en)
				wr_pend <= (word_idx != '0);
		end
	end

	// at most one write per word, and words are several cycles apart
	a_wr_single: assert property (@(posedge GSSL_RXCLK) disable iff (rst_in)
		rx_dpram_wr |=> !rx_dpram_wr);

endmodule

`default_nettype wire

// File: gssl_rx.f
+incdir+verif
design/gssl_symbol_pkg.sv
design/gssl_frame_pkg.sv
design/gssl_symbol_classifier.sv
design/gssl_frame_sequencer.sv
design/gssl_word_builder.sv
design/gssl_rx_receiver.sv
verif/gssl_rx_tb.sv

// File: verif/gssl_rx_tb_tasks.svh
`ifndef GSSL_RX_TB_TASKS_SVH
`define GSSL_RX_TB_TASKS_SVH

task automatic fail_run(input string why);
	$display("%s", why);
	$display("*** TEST FAILED ***");
	$fatal(1, "simulation stopped at the first error");
endtask

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		fail_run($sformatf("FAIL %s: got 0x%h expected 0x%h", name, got, exp));
endtask

// expected checksum byte of one word from L, its four bytes and k
function automatic logic [7:0] word_checksum(input logic [7:0] b0, b1, b2, b3, len, k,
	input logic pos);
	logic [7:0] s;
	s = b0 + b1 + b2 + b3 + len - k;
	return pos ? s + 8'd1 : ~s;
endfunction

// one symbol per cycle on the falling edge
task automatic send_symbol(input logic k, input logic [BYTE_W-1:0] d);
	@(negedge GSSL_RXCLK);
	decode_k    <= k;
	decode_data <= d;
endtask

task automatic send_ttc();
	send_symbol(1'b1, K_TTC);
	exp_ttc++;
endtask

task automatic flush_idle();
	repeat (FLUSH_SYMS) send_symbol(1'b1, K_SYNC);
endtask

task automatic send_word(input logic [7:0] b0, b1, b2, b3, len, k, input bit corrupt,
	input bit ttc_inline);
	logic [7:0] chs;
	chs = word_checksum(b0, b1, b2, b3, len, k, chs_ctrl);
	if (corrupt)
		chs = chs ^ 8'h5a;
	send_symbol(1'b0, b0);
	send_symbol(1'b0, b1);
	// trigger and a stalling SYNC in the middle of the word
	if (ttc_inline)
	begin
		send_ttc();
		send_symbol(1'b1, K_SYNC);
	end
	send_symbol(1'b0, b2);
	send_symbol(1'b0, b3);
	send_symbol(1'b0, chs);
	send_symbol(1'b1, K_SYNC);
endtask

// keeps the line idle until the awaited pulse has been counted
task automatic wait_outcome(input bit on_seq_err, input int target);
	int n;
	n = 0;
	while ((on_seq_err ? seq_err_count : done_count) < target)
	begin
		if (n == WAIT_MAX)
			fail_run(on_seq_err ? "no sequence error pulse arrived in time" :
				"no frame done pulse arrived in time");
		else
		begin
			send_symbol(1'b1, K_SYNC);
			n++;
		end
	end
endtask

task automatic send_frame(input int len, input logic [7:0] base, input bit pos,
	input int corrupt_k, input int ttc_k);
	logic [7:0] d0, d1, d2, d3;
	chs_ctrl <= pos;
	send_symbol(1'b1, K_SOF);
	d2 = 8'($random(seed));
	d3 = 8'($random(seed));
	send_word(8'(len), base, d2, d3, 8'(len), 8'd0, corrupt_k == 0, ttc_k == 0);
	check_value("rx_frame_busy", 32'(rx_frame_busy), 32'd1);
	for (int k = 1; k <= len; k++)
	begin
		d0 = 8'($random(seed));
		d1 = 8'($random(seed));
		d2 = 8'($random(seed));
		d3 = 8'($random(seed));
		send_word(d0, d1, d2, d3, 8'(len), 8'(k), corrupt_k == k, ttc_k == k);
		exp_wr.push_back({base + 8'(k) - 8'd1, d3, d2, d1, d0});
	end
	send_symbol(1'b1, K_EOF);
	exp_done++;
	if (corrupt_k >= 0)
		exp_chs++;
	wait_outcome(1'b0, exp_done);
	flush_idle();
endtask

task automatic check_writes();
	logic [ADDR_W+WORD_W-1:0] got;
	logic [ADDR_W+WORD_W-1:0] exp;
	check_value("rx_dpram_wr count", obs_wr.size(), exp_wr.size());
	while (exp_wr.size() > 0)
	begin
		got = obs_wr.pop_front();
		exp = exp_wr.pop_front();
		check_value("rx_dpram_waddress", 32'(got[ADDR_W+WORD_W-1:WORD_W]),
			32'(exp[ADDR_W+WORD_W-1:WORD_W]));
		check_value("rx_dpram_data", got[WORD_W-1:0], exp[WORD_W-1:0]);
	end
endtask

task automatic check_counts();
	check_value("rx_ttc_trigger pulses", ttc_count, exp_ttc);
	check_value("rx_frame_done pulses", done_count, exp_done);
	check_value("rx_frame_chs_err pulses", chs_count, exp_chs);
	check_value("rx_frame_seq_err pulses", seq_err_count, exp_seq_err);
endtask

task automatic check_frame_result(input logic [7:0] base, input int len);
	check_writes();
	check_counts();
	check_value("rx_frame_head_data", 32'(rx_frame_head_data), 32'({base, 8'(len)}));
	check_value("rx_frame_busy", 32'(rx_frame_busy), 32'd0);
endtask

`endif

// File: verif/gssl_rx_tb.sv
`timescale 1ns/1ns
`default_nettype none

module gssl_rx_tb;

	import gssl_symbol_pkg::*;
	import gssl_frame_pkg::*;

	localparam int CLK_NS       = 20;
	localparam int RESET_CYCLES = 3;
	localparam int WAIT_MAX     = 16;
	localparam int FLUSH_SYMS   = 4;
	// SOF, EOF, head and three data words, plus an inline TTC and SYNC
	localparam int FRAME_SYMS   = 2 + 4 * 6 + 2;
	// idle test, lone TTC, then seven frames with their waits
	localparam int SYM_BUDGET   = 12 + 1 + FLUSH_SYMS + 7 * (FRAME_SYMS + WAIT_MAX + FLUSH_SYMS);
	localparam int WATCHDOG_NS  = (SYM_BUDGET + RESET_CYCLES) * CLK_NS + 2000;
	// a K-code outside the known set
	localparam logic [BYTE_W-1:0] K_UNKNOWN = 8'h7c;

	logic                  GSSL_RXCLK = 1'b0;
	logic                  rst_in;
	logic                  chs_ctrl;
	logic                  decode_k;
	logic [BYTE_W-1:0]     decode_data;
	logic [WORD_W-1:0]     rx_dpram_data;
	logic [ADDR_W-1:0]     rx_dpram_waddress;
	logic                  rx_dpram_wr;
	logic [2*ADDR_W-1:0]   rx_frame_head_data;
	logic                  rx_ttc_trigger;
	logic                  rx_frame_busy;
	logic                  rx_frame_done;
	logic                  rx_frame_chs_err;
	logic                  rx_frame_seq_err;

	integer                   seed;
	logic [ADDR_W+WORD_W-1:0] obs_wr[$];
	logic [ADDR_W+WORD_W-1:0] exp_wr[$];
	int ttc_count = 0;
	int done_count = 0;
	int chs_count = 0;
	int seq_err_count = 0;
	int exp_ttc = 0;
	int exp_done = 0;
	int exp_chs = 0;
	int exp_seq_err = 0;

	gssl_rx_receiver dut_i
	(
		.GSSL_RXCLK         (GSSL_RXCLK),
		.rst_in             (rst_in),
		.chs_ctrl           (chs_ctrl),
		.decode_k           (decode_k),
		.decode_data        (decode_data),
		.rx_dpram_data      (rx_dpram_data),
		.rx_dpram_waddress  (rx_dpram_waddress),
		.rx_dpram_wr        (rx_dpram_wr),
		.rx_frame_head_data (rx_frame_head_data),
		.rx_ttc_trigger     (rx_ttc_trigger),
		.rx_frame_busy      (rx_frame_busy),
		.rx_frame_done      (rx_frame_done),
		.rx_frame_chs_err   (rx_frame_chs_err),
		.rx_frame_seq_err   (rx_frame_seq_err)
	);

	always #(CLK_NS / 2) GSSL_RXCLK = ~GSSL_RXCLK;

	// values read at the rising edge are the ones held over the past cycle
	always @(posedge GSSL_RXCLK)
	begin
		if (!rst_in)
		begin
			if (rx_dpram_wr)
				obs_wr.push_back({rx_dpram_waddress, rx_dpram_data});
			if (rx_ttc_trigger)
				ttc_count++;
			if (rx_frame_done)
				done_count++;
			if (rx_frame_chs_err)
				chs_count++;
			if (rx_frame_seq_err)
				seq_err_count++;
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		fail_run("watchdog expired before the tests finished");
	end

	`include "gssl_rx_tb_tasks.svh"

	task automatic test_idle();
		repeat (12)
		begin
			send_symbol(1'b1, K_SYNC);
			check_value("rx_dpram_wr", 32'(rx_dpram_wr), 32'd0);
			check_value("rx_ttc_trigger", 32'(rx_ttc_trigger), 32'd0);
			check_value("rx_frame_busy", 32'(rx_frame_busy), 32'd0);
			check_value("rx_frame_done", 32'(rx_frame_done), 32'd0);
			check_value("rx_frame_chs_err", 32'(rx_frame_chs_err), 32'd0);
			check_value("rx_frame_seq_err", 32'(rx_frame_seq_err), 32'd0);
		end
		check_writes();
		check_counts();
	endtask

	task automatic test_frames();
		logic [7:0] base;
		base = 8'($random(seed));
		send_frame(3, base, 1'b1, -1, -1);
		check_frame_result(base, 3);
		// negative polarity with addresses wrapping past 255
		send_frame(3, 8'hfe, 1'b0, -1, -1);
		check_frame_result(8'hfe, 3);
	endtask

	task automatic test_chs_error();
		logic [7:0] base;
		base = 8'($random(seed));
		send_frame(3, base, 1'b0, 2, -1);
		check_frame_result(base, 3);
	endtask

	task automatic test_ttc();
		logic [7:0] base;
		send_ttc();
		flush_idle();
		check_counts();
		base = 8'($random(seed));
		send_frame(3, base, 1'b1, -1, 1);
		check_frame_result(base, 3);
	endtask

	// bad symbol lands on byte 2 of data word 2
	task automatic test_abort(input bit use_eof);
		logic [7:0] base, d0, d1, d2, d3;
		base = 8'($random(seed));
		d0 = 8'($random(seed));
		d1 = 8'($random(seed));
		d2 = 8'($random(seed));
		d3 = 8'($random(seed));
		chs_ctrl <= 1'b1;
		send_symbol(1'b1, K_SOF);
		send_word(8'd3, base, d2, d3, 8'd3, 8'd0, 1'b0, 1'b0);
		send_word(d0, d1, d2, d3, 8'd3, 8'd1, 1'b0, 1'b0);
		exp_wr.push_back({base, d3, d2, d1, d0});
		check_value("rx_frame_busy", 32'(rx_frame_busy), 32'd1);
		send_symbol(1'b0, d1);
		send_symbol(1'b0, d0);
		send_symbol(1'b1, use_eof ? K_EOF : K_UNKNOWN);
		exp_seq_err++;
		wait_outcome(1'b1, exp_seq_err);
		flush_idle();
		check_writes();
		check_counts();
		check_value("rx_frame_busy", 32'(rx_frame_busy), 32'd0);
	endtask

	task automatic test_empty();
		logic [7:0] base;
		base = 8'($random(seed));
		send_frame(0, base, 1'b0, -1, -1);
		check_frame_result(base, 0);
	endtask

	initial
	begin
		seed        = 32'he7a1980a;
		rst_in      = 1'b1;
		chs_ctrl    = 1'b0;
		decode_k    = 1'b1;
		decode_data = K_SYNC;
		repeat (RESET_CYCLES) @(posedge GSSL_RXCLK);
		@(negedge GSSL_RXCLK);
		rst_in <= 1'b0;

		test_idle();
		test_frames();
		test_chs_error();
		test_ttc();
		test_abort(1'b1);
		test_abort(1'b0);
		test_empty();

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
